//--- hw/audio_if_pkg.sv
package audio_if_pkg;

    ////////////////////////////////////////////////////////////
    // Frame constants
    ////////////////////////////////////////////////////////////

    localparam int sample_bits = 16;         // One audio word
    localparam int n_channels  = 2;          // Lane 0 left, lane 1 right

    typedef logic [sample_bits-1:0] sample_t;

    ////////////////////////////////////////////////////////////
    // Tracker broadcast to lanes and output mux
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic bclk_rise;                     // Single-cycle pulse
        logic bclk_fall;                     // Single-cycle pulse
        logic wclk_rise;                     // Right phase starts
        logic wclk_fall;                     // Left phase starts
        logic wclk_level;                    // Low for left, high for right
        logic dout_bit;                      // Codec data, aligned with pulses
        logic locked;                        // Frame boundary seen
    } serial_strobe_t;

    // Host read side of one channel
    typedef struct packed {
        sample_t data;                       // Word from last accepted read
        logic    valid;                      // One cycle after accepted read
        logic    empty;                      // Nothing buffered
    } rx_port_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mode_normal   = 2'd0,                // Lanes drive din
        mode_loopback = 2'd1,                // dout echoed onto din
        mode_mute     = 2'd2                 // din held low
    } link_mode_t;

    typedef enum logic {
        sync_hunt   = 1'b0,                  // Waiting for a wclk edge
        sync_locked = 1'b1                   // Frame aligned
    } sync_state_t;

endpackage

//--- hw/serial_clock_tracker.sv
`timescale 1ns/1ps

module serial_clock_tracker import audio_if_pkg::*; (
    input  logic           aic3204_mclk,
    input  logic           rst,
    input  logic           aic3204_bclk,
    input  logic           aic3204_wclk,
    input  logic           aic3204_dout,
    output serial_strobe_t strobe
);

    logic [1:0]     bclk_sync;               // Two-stage synchronizers
    logic [1:0]     wclk_sync;
    logic [1:0]     dout_sync;
    logic           bclk_prev;               // Last synchronized level
    logic           wclk_prev;
    logic           bclk_up;
    logic           bclk_down;
    logic           wclk_up;
    logic           wclk_down;
    sync_state_t    state;
    sync_state_t    state_next;
    serial_strobe_t strobe_q;

    ////////////////////////////////////////////////////////////
    // Synchronizers and edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        dout_sync <= {dout_sync[0], aic3204_dout};     // Data path, no reset
    end

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            bclk_sync <= '0;
            wclk_sync <= '0;
            bclk_prev <= 1'b0;
            wclk_prev <= 1'b0;
        end else begin
            bclk_sync <= {bclk_sync[0], aic3204_bclk};
            wclk_sync <= {wclk_sync[0], aic3204_wclk};
            bclk_prev <= bclk_sync[1];
            wclk_prev <= wclk_sync[1];
        end
    end

    assign bclk_up   = bclk_sync[1] & ~bclk_prev;
    assign bclk_down = ~bclk_sync[1] & bclk_prev;
    assign wclk_up   = wclk_sync[1] & ~wclk_prev;
    assign wclk_down = ~wclk_sync[1] & wclk_prev;

    // Lock on first wclk edge so the next phase is whole
    always_comb begin
        state_next = state;
        if (state == sync_hunt && (wclk_up || wclk_down)) begin
            state_next = sync_locked;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe register, third stage of delay
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            state    <= sync_hunt;
            strobe_q <= '0;
        end else begin
            state               <= state_next;
            strobe_q.bclk_rise  <= bclk_up;
            strobe_q.bclk_fall  <= bclk_down;
            strobe_q.wclk_rise  <= wclk_up;
            strobe_q.wclk_fall  <= wclk_down;
            strobe_q.wclk_level <= wclk_sync[1];
            strobe_q.dout_bit   <= dout_sync[1];
            strobe_q.locked     <= (state_next == sync_locked);  // Same cycle as edge
        end
    end

    assign strobe = strobe_q;

endmodule

//--- hw/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import audio_if_pkg::*; #(
    parameter int depth = 16
) (
    input  logic     aic3204_mclk,
    input  logic     rst,
    input  logic     wr_en,
    input  sample_t  wr_data,
    output logic     full,
    input  logic     rd_en,
    output rx_port_t rd_port
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_bits = $clog2(depth + 1);

    sample_t             mem [depth];        // Sample storage
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;              // Occupancy
    logic                empty;
    logic                wr_ok;              // Accepted write
    logic                rd_ok;              // Accepted read
    sample_t             rd_data;
    logic                rd_valid;

    // Wrap at depth, not at a power of two
    function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] ptr);
        if (ptr == ptr_bits'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == cnt_bits'(depth));
    assign wr_ok = wr_en && !full;           // Drop when full
    assign rd_ok = rd_en && !empty;          // Ignore when empty

    ////////////////////////////////////////////////////////////
    // Pointers and count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_ok) wr_ptr <= ptr_next(wr_ptr);
            if (rd_ok) rd_ptr <= ptr_next(rd_ptr);
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Idle or both
            endcase
            rd_valid <= rd_ok;                   // One-cycle read latency
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage and read register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];              // Held until next read
        end
    end

    assign rd_port = '{data: rd_data, valid: rd_valid, empty: empty};

endmodule

//--- hw/channel_lane.sv
`timescale 1ns/1ps

module channel_lane import audio_if_pkg::*; #(
    parameter bit phase      = 1'b0,         // wclk level owning this lane
    parameter int fifo_depth = 16
) (
    input  logic           aic3204_mclk,
    input  logic           rst,
    input  serial_strobe_t strobe,
    input  logic           rx_rd_en,
    output rx_port_t       rx_port,
    input  logic           tx_wr_en,
    input  sample_t        tx_wr_data,
    output logic           tx_full,
    output logic           tx_bit
);

    logic     active;                        // Inside own phase
    logic     phase_start;
    logic     phase_end;
    sample_t  rx_shift;                      // Receive shift register
    sample_t  rx_word;                       // Captured word for push
    logic     rx_armed;                      // Whole phase seen
    logic     rx_push;
    sample_t  tx_reg;                        // Transmit shift register
    logic     tx_load;                       // FIFO read data arriving
    rx_port_t tx_rd;
    sample_t  load_word;

    assign active      = strobe.locked && (strobe.wclk_level == phase);
    assign phase_start = strobe.locked && (phase ? strobe.wclk_rise : strobe.wclk_fall);
    assign phase_end   = strobe.locked && (phase ? strobe.wclk_fall : strobe.wclk_rise);

    ////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (active && strobe.bclk_rise) begin
            rx_shift <= {rx_shift[sample_bits-2:0], strobe.dout_bit};  // MSB first
        end
        if (phase_end) begin
            rx_word <= rx_shift;                 // Last 16 bits of phase
        end
    end

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            rx_armed <= 1'b0;
            rx_push  <= 1'b0;
        end else begin
            if (phase_start) rx_armed <= 1'b1;   // Skip partial first phase
            rx_push <= phase_end && rx_armed;    // One cycle after end strobe
        end
    end

    sample_fifo #(
        .depth (fifo_depth)
    ) u_rx_fifo (
        .aic3204_mclk (aic3204_mclk),
        .rst          (rst),
        .wr_en        (rx_push),
        .wr_data      (rx_word),
        .full         (),
        .rd_en        (rx_rd_en),
        .rd_port      (rx_port)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////

    sample_fifo #(
        .depth (fifo_depth)
    ) u_tx_fifo (
        .aic3204_mclk (aic3204_mclk),
        .rst          (rst),
        .wr_en        (tx_wr_en),
        .wr_data      (tx_wr_data),
        .full         (tx_full),
        .rd_en        (phase_start),         // Pop at phase start
        .rd_port      (tx_rd)
    );

    assign load_word = tx_rd.valid ? tx_rd.data : '0;  // Underrun plays zero

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            tx_load <= 1'b0;
            tx_reg  <= '0;
        end else begin
            tx_load <= phase_start;
            if (tx_load) begin
                tx_reg <= load_word;             // Completes one cycle after strobe
            end else if (active && strobe.bclk_fall && !phase_start) begin
                tx_reg <= {tx_reg[sample_bits-2:0], 1'b0};
            end
        end
    end

    // Bypass during load keeps MSB on the same cycle as later bits
    assign tx_bit = tx_load ? load_word[sample_bits-1] : tx_reg[sample_bits-1];

endmodule

//--- hw/serial_out_mux.sv
`timescale 1ns/1ps

module serial_out_mux import audio_if_pkg::*; (
    input  logic                  aic3204_mclk,
    input  logic                  rst,
    input  serial_strobe_t        strobe,
    input  link_mode_t            mode,
    input  logic [n_channels-1:0] tx_bits,
    output logic                  din
);

    logic level_d;                           // Lane select, aligned to lane bypass
    logic dout_d;                            // Loopback, matches lane latency
    logic locked_d;

    ////////////////////////////////////////////////////////////
    // Alignment stage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            level_d  <= 1'b0;
            dout_d   <= 1'b0;
            locked_d <= 1'b0;
        end else begin
            level_d  <= strobe.wclk_level;
            dout_d   <= strobe.dout_bit;
            locked_d <= strobe.locked;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aic3204_mclk) begin
        if (rst) begin
            din <= 1'b0;
        end else if (!locked_d) begin
            din <= 1'b0;                         // Quiet until frame lock
        end else begin
            case (mode)
                mode_normal:   din <= tx_bits[level_d];
                mode_loopback: din <= dout_d;    // Five cycles after pin
                default:       din <= 1'b0;      // Mute
            endcase
        end
    end

endmodule

//--- hw/aic3204_audio_if.sv
`timescale 1ns/1ps

module aic3204_audio_if import audio_if_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic                             aic3204_mclk,
    input  logic                             rst,

    ////////////////////////////////////////////////////////////
    // Codec pins
    ////////////////////////////////////////////////////////////

    input  logic                             aic3204_bclk,
    input  logic                             aic3204_wclk,
    input  logic                             aic3204_dout,
    output logic                             aic3204_din,
    input  link_mode_t                       mode,

    ////////////////////////////////////////////////////////////
    // Host side, index 0 left, 1 right
    ////////////////////////////////////////////////////////////

    input  logic     [n_channels-1:0]        rx_rd_en,
    output rx_port_t [n_channels-1:0]        rx_port,
    input  logic     [n_channels-1:0]        tx_wr_en,
    input  sample_t  [n_channels-1:0]        tx_wr_data,
    output logic     [n_channels-1:0]        tx_full
);

    serial_strobe_t        strobe;           // Shared edge pulses
    logic [n_channels-1:0] tx_bits;          // Lane MSBs to mux

    serial_clock_tracker u_tracker (
        .aic3204_mclk (aic3204_mclk),
        .rst          (rst),
        .aic3204_bclk (aic3204_bclk),
        .aic3204_wclk (aic3204_wclk),
        .aic3204_dout (aic3204_dout),
        .strobe       (strobe)
    );

    // One lane per wclk phase
    for (genvar ch = 0; ch < n_channels; ch++) begin : g_lane
        channel_lane #(
            .phase      (ch),
            .fifo_depth (fifo_depth)
        ) u_lane (
            .aic3204_mclk (aic3204_mclk),
            .rst          (rst),
            .strobe       (strobe),
            .rx_rd_en     (rx_rd_en[ch]),
            .rx_port      (rx_port[ch]),
            .tx_wr_en     (tx_wr_en[ch]),
            .tx_wr_data   (tx_wr_data[ch]),
            .tx_full      (tx_full[ch]),
            .tx_bit       (tx_bits[ch])
        );
    end

    serial_out_mux u_out_mux (
        .aic3204_mclk (aic3204_mclk),
        .rst          (rst),
        .strobe       (strobe),
        .mode         (mode),
        .tx_bits      (tx_bits),
        .din          (aic3204_din)
    );

endmodule

//--- sim/sample_fifo_checker.sv
`timescale 1ns/1ps

module sample_fifo_checker import audio_if_pkg::*; #(
    parameter int depth    = 16,
    parameter int cnt_bits = 5
) (
    input logic                aic3204_mclk,
    input logic                rst,
    input logic                rd_en,
    input logic                full,
    input rx_port_t            rd_port,
    input logic [cnt_bits-1:0] count
);

    int   fail_count = 0;                    // Read by the testbench at the end
    logic rd_ok;                             // Read that the FIFO accepts

    assign rd_ok = rd_en && !rd_port.empty;

    ////////////////////////////////////////////////////////////
    // Flag and latency rules
    ////////////////////////////////////////////////////////////

    a_flags_exclusive: assert property (@(posedge aic3204_mclk) disable iff (rst)
        !(full && rd_port.empty))
        else begin
            fail_count++;
            $error("full and empty high together");
        end

    a_valid_source: assert property (@(posedge aic3204_mclk) disable iff (rst)
        rd_port.valid |-> $past(rd_ok))
        else begin
            fail_count++;
            $error("valid without an accepted read one cycle earlier");
        end

    a_valid_follows: assert property (@(posedge aic3204_mclk) disable iff (rst)
        rd_ok |=> rd_port.valid)
        else begin
            fail_count++;
            $error("accepted read not followed by valid");
        end

    a_count_bound: assert property (@(posedge aic3204_mclk) disable iff (rst)
        count <= cnt_bits'(depth))
        else begin
            fail_count++;
            $error("occupancy above depth");
        end

endmodule

bind sample_fifo sample_fifo_checker #(
    .depth    (depth),
    .cnt_bits (cnt_bits)
) u_fifo_chk (
    .aic3204_mclk (aic3204_mclk),
    .rst          (rst),
    .rd_en        (rd_en),
    .full         (full),
    .rd_port      (rd_port),
    .count        (count)
);

//--- sim/tb_aic3204_audio_if.sv
`timescale 1ns/1ps

module tb_aic3204_audio_if import audio_if_pkg::*; ();

    localparam int fifo_depth = 16;
    localparam int n_frames   = 16;          // Lines in the stimulus file
    localparam int clk_period = 100;         // ns
    localparam longint watchdog_ns =
        longint'(n_frames + fifo_depth + 4) * 32 * 8 * clk_period * 2 + 16 * clk_period;

    logic                             aic3204_mclk;
    logic                             rst;
    logic                             aic3204_bclk;
    logic                             aic3204_wclk;
    logic                             aic3204_dout;
    logic                             aic3204_din;
    link_mode_t                       mode;
    logic     [n_channels-1:0]        rx_rd_en;
    rx_port_t [n_channels-1:0]        rx_port;
    logic     [n_channels-1:0]        tx_wr_en;
    sample_t  [n_channels-1:0]        tx_wr_data;
    logic     [n_channels-1:0]        tx_full;

    logic [15:0] stim [n_frames*5];          // Mode, play L/R, codec L/R per frame
    sample_t     fill_words [fifo_depth+1];
    sample_t     din_l;                      // Words heard on din
    sample_t     din_r;

    aic3204_audio_if #(
        .fifo_depth (fifo_depth)
    ) dut_i (
        .aic3204_mclk (aic3204_mclk),
        .rst          (rst),
        .aic3204_bclk (aic3204_bclk),
        .aic3204_wclk (aic3204_wclk),
        .aic3204_dout (aic3204_dout),
        .aic3204_din  (aic3204_din),
        .mode         (mode),
        .rx_rd_en     (rx_rd_en),
        .rx_port      (rx_port),
        .tx_wr_en     (tx_wr_en),
        .tx_wr_data   (tx_wr_data),
        .tx_full      (tx_full)
    );

    always #(clk_period/2) aic3204_mclk = ~aic3204_mclk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic sample_t stim_word(input int f, input int col);
        return stim[f*5 + col];
    endfunction

    // What din must carry for one phase
    function automatic sample_t expected_din(input link_mode_t m, input sample_t play,
                                             input sample_t codec);
        case (m)
            mode_normal:   return play;
            mode_loopback: return codec;     // Echo of dout
            default:       return '0;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // Codec side, one frame, bclk = mclk/8
    task automatic serial_frame(input sample_t left_out, input sample_t right_out,
                                output sample_t left_in, output sample_t right_in);
        logic [15:0] send [2];
        logic [15:0] recv [2];
        send[0] = left_out;
        send[1] = right_out;
        for (int ph = 0; ph < 2; ph++) begin
            for (int b = 15; b >= 0; b--) begin
                aic3204_bclk = 1'b0;                 // dout and wclk move on fall
                aic3204_wclk = ph[0];
                aic3204_dout = send[ph][b];
                repeat (4) @(negedge aic3204_mclk);
                aic3204_bclk = 1'b1;
                repeat (2) @(negedge aic3204_mclk);
                recv[ph][b] = aic3204_din;           // din settled 5 cycles after fall
                repeat (2) @(negedge aic3204_mclk);
            end
        end
        left_in  = recv[0];
        right_in = recv[1];
    endtask

    task automatic read_word(input int ch, input bit exp_valid, input sample_t exp_data);
        rx_rd_en[ch] = 1'b1;
        @(negedge aic3204_mclk);
        rx_rd_en[ch] = 1'b0;
        check_value(rx_port[ch].valid, exp_valid, $sformatf("lane %0d valid after read", ch));
        if (exp_valid) begin
            check_value(rx_port[ch].data, exp_data, $sformatf("lane %0d read data", ch));
        end
        @(negedge aic3204_mclk);
        check_value(rx_port[ch].valid, 1'b0, $sformatf("lane %0d valid one cycle", ch));
    endtask

    task automatic write_word(input int ch, input sample_t data);
        tx_wr_en[ch]   = 1'b1;
        tx_wr_data[ch] = data;
        @(negedge aic3204_mclk);
        tx_wr_en[ch]   = 1'b0;
    endtask

    // Reads last frame, then queues next frame after the right pop
    task automatic host_frame(input bit lv, input sample_t ld, input bit rv,
                              input sample_t rd, input bit wr, input sample_t wl,
                              input sample_t wrr);
        repeat (12) @(negedge aic3204_mclk);         // Right push lands by now
        read_word(0, lv, ld);
        read_word(1, rv, rd);
        if (wr) begin
            repeat (144) @(negedge aic3204_mclk);    // Past mid-frame pop
            write_word(0, wl);
            write_word(1, wrr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          fifo_fails;
        logic [31:0] seed;
        bit          wr;
        sample_t     wl;
        sample_t     wrr;
        aic3204_mclk = 1'b0;
        rst          = 1'b1;
        aic3204_bclk = 1'b0;
        aic3204_wclk = 1'b0;
        aic3204_dout = 1'b0;
        mode         = mode_normal;
        rx_rd_en     = '0;
        tx_wr_en     = '0;
        tx_wr_data   = '0;
        $readmemh("sim/frame_stimulus.txt", stim);
        repeat (16) @(negedge aic3204_mclk);
        rst = 1'b0;
        @(negedge aic3204_mclk);
        for (int ch = 0; ch < n_channels; ch++) begin
            check_value(rx_port[ch].empty, 1'b1, "empty after reset");
            check_value(rx_port[ch].valid, 1'b0, "valid after reset");
            check_value(tx_full[ch], 1'b0, "tx_full after reset");
        end

        // Unlocked left half, lock on the wclk rise
        mode = mode_loopback;                        // Echo would show ones without lock
        fork
            serial_frame(16'hffff, '0, din_l, din_r);
            host_frame(0, '0, 0, '0, 1, stim_word(0, 1), stim_word(0, 2));
        join
        check_value(din_l, '0, "din before lock");
        check_value(din_r, '0, "din in first locked phase");

        for (int f = 0; f < n_frames; f++) begin
            mode = link_mode_t'(stim[f*5][1:0]);
            wr   = (f < n_frames - 1);
            wl   = wr ? stim_word(f + 1, 1) : '0;
            wrr  = wr ? stim_word(f + 1, 2) : '0;
            fork
                serial_frame(stim_word(f, 3), stim_word(f, 4), din_l, din_r);
                if (f == 0) begin
                    host_frame(0, '0, 1, '0, wr, wl, wrr);   // Right word of lock phase
                end else begin
                    host_frame(1, stim_word(f - 1, 3), 1, stim_word(f - 1, 4), wr, wl, wrr);
                end
            join
            check_value(din_l, expected_din(mode, stim_word(f, 1), stim_word(f, 3)),
                        $sformatf("frame %0d left din", f));
            check_value(din_r, expected_din(mode, stim_word(f, 2), stim_word(f, 4)),
                        $sformatf("frame %0d right din", f));
        end

        // Flush the last frame's words, playback FIFOs are empty
        mode = mode_normal;
        fork
            serial_frame('0, '0, din_l, din_r);
            host_frame(1, stim_word(n_frames - 1, 3), 1, stim_word(n_frames - 1, 4), 0,
                       '0, '0);
        join
        check_value(din_l, '0, "left underrun word");
        check_value(din_r, '0, "right underrun word");

        ////////////////////////////////////////////////////////////
        // FIFO fill on lane 0
        ////////////////////////////////////////////////////////////

        seed = 32'h5107;
        for (int k = 0; k <= fifo_depth; k++) begin
            seed          = lcg_next(seed);
            fill_words[k] = seed[31:16];
            check_value(tx_full[0], (k == fifo_depth), $sformatf("tx_full before write %0d", k));
            write_word(0, fill_words[k]);            // Last one is dropped
        end
        for (int k = 0; k <= fifo_depth; k++) begin
            serial_frame('0, '0, din_l, din_r);
            check_value(din_l, (k < fifo_depth) ? fill_words[k] : '0,
                        $sformatf("fill frame %0d left din", k));
            check_value(din_r, '0, $sformatf("fill frame %0d right din", k));
        end

        fifo_fails = dut_i.g_lane[0].u_lane.u_rx_fifo.u_fifo_chk.fail_count
                   + dut_i.g_lane[0].u_lane.u_tx_fifo.u_fifo_chk.fail_count
                   + dut_i.g_lane[1].u_lane.u_rx_fifo.u_fifo_chk.fail_count
                   + dut_i.g_lane[1].u_lane.u_tx_fifo.u_fifo_chk.fail_count;
        check_value(fifo_fails, 0, "FIFO assertion failures");

        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(watchdog_ns);
        $display("Simulation timed out after %0d ns without finishing", watchdog_ns);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- sim/frame_stimulus.txt
// One frame per line: mode (0 normal, 1 loopback, 2 mute),
// left play, right play, left codec, right codec
0000 a5c3 3c5a 1234 fedc
0000 8001 7ffe 0f0f f0f0
0001 1111 2222 c0de beef
0000 ffff 0000 5555 aaaa
0002 4321 8765 9abc def0
0000 0001 8000 7e81 18e7
0001 dead f00d 6b2d 94d2
0000 2468 ace0 1357 9bdf
0002 3141 5926 5358 9793
0000 cafe babe 0000 ffff
0001 0000 0000 a0a0 0505
0000 9999 6666 3333 cccc
0002 feed face 4a4a b5b5
0000 0f1e 2d3c 4b5a 6978
0001 7777 8888 e1e1 1e1e
0000 5a5a a5a5 0102 0408

//--- sources.f
hw/audio_if_pkg.sv
hw/serial_clock_tracker.sv
hw/sample_fifo.sv
hw/channel_lane.sv
hw/serial_out_mux.sv
hw/aic3204_audio_if.sv
sim/sample_fifo_checker.sv
sim/tb_aic3204_audio_if.sv
